/* avmm_mem_model.sv */
// Behavioural Avalon-MM slave with no bursts and waitrequest tied low
// Read data comes back two cycles after the read cycle and reset clears every word
`timescale 1ns/100ps
`default_nettype none

module avmm_mem_model #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 10
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [ADDR_W-1:0]   avmm_address,
   input  logic                avmm_read,
   input  logic                avmm_write,
   input  logic [DATA_W-1:0]   avmm_writedata,
   input  logic [DATA_W/8-1:0] avmm_byteenable,
   output logic                avmm_waitrequest,
   output logic [DATA_W-1:0]   avmm_readdata,
   output logic                avmm_readdatavalid
);

   localparam int BE_W  = DATA_W / 8;
   localparam int DEPTH = 2 ** ADDR_W;

   typedef enum {
      idle_i,
      pend_i,
      resp_i
   } state_idx_t;

   // One-hot read pipeline
   typedef enum logic [2:0] {
      IDLE = 3'b1 << idle_i,
      PEND = 3'b1 << pend_i,
      RESP = 3'b1 << resp_i
   } state_t;

   state_t            state;
   state_t            next_state;
   logic [DATA_W-1:0] mem [DEPTH];
   logic [ADDR_W-1:0] rd_addr;

   // The model never stalls the master
   assign avmm_waitrequest   = 1'b0;
   assign avmm_readdatavalid = (state == RESP);

   always_comb begin
      next_state = IDLE;
      unique case (state)
         IDLE:    next_state = (avmm_read && !avmm_write) ? PEND : IDLE;
         PEND:    next_state = RESP;
         RESP:    next_state = avmm_read ? PEND : IDLE;
         default: next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= next_state;
         assert (!(avmm_read && avmm_write))
            else $error("avmm_mem_model: read and write in the same cycle");
      end
   end

   // Writes commit on the sampling edge under the byte enables
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (avmm_write) begin
         for (int b = 0; b < BE_W; b++) begin
            if (avmm_byteenable[b]) begin
               mem[avmm_address][8*b +: 8] <= avmm_writedata[8*b +: 8];
            end
         end
      end
   end

   // Read address is captured with the request and the array is read one cycle later
   always_ff @(posedge clk) begin
      if (avmm_read) begin
         rd_addr <= avmm_address;
      end
      if (state == PEND) begin
         avmm_readdata <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

/* copy_csr.sv */
// Host register block with write-only registers and no back-pressure
// Writes are dropped while the engine is busy or a start is pending
`timescale 1ns/100ps
`default_nettype none

module copy_csr #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 10
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                cfg_write,
   input  mem_pkg::reg_t       cfg_addr,
   input  logic [DATA_W-1:0]   cfg_wdata,
   input  logic                busy,
   output logic                start,
   output mem_pkg::op_t        op,
   output logic [ADDR_W-1:0]   src_addr,
   output logic [ADDR_W-1:0]   dst_addr,
   output logic [ADDR_W-1:0]   len,
   output logic [DATA_W-1:0]   pattern,
   output logic [DATA_W/8-1:0] mask
);

   import mem_pkg::*;

   localparam int BE_W = DATA_W / 8;

   logic wr_ok;

   // A write only lands when nothing is running and no start is in flight
   // so the engine sees settings that cannot move under it
   assign wr_ok = cfg_write && !busy && !start;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         start    <= 1'b0;
         op       <= OP_COPY;
         src_addr <= '0;
         dst_addr <= '0;
         len      <= '0;
         pattern  <= '0;
         mask     <= '0;
      end else begin
         // Start is a single-cycle strobe by default
         start <= 1'b0;
         if (wr_ok) begin
            unique case (cfg_addr)
               REG_SRC:     src_addr <= cfg_wdata[ADDR_W-1:0];
               REG_DST:     dst_addr <= cfg_wdata[ADDR_W-1:0];
               REG_LEN:     len      <= cfg_wdata[ADDR_W-1:0];
               REG_PATTERN: pattern  <= cfg_wdata;
               REG_MASK:    mask     <= cfg_wdata[BE_W-1:0];
               REG_CTRL: begin
                  // The op code is taken even without the start bit
                  op    <= op_t'(cfg_wdata[CTRL_OP_LSB +: $bits(op_t)]);
                  start <= cfg_wdata[CTRL_START_BIT];
               end
               default: begin
                  // Unused address codes are silently ignored
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* copy_engine.sv */
// Avalon-MM master for COPY, FILL and CHECK with one read outstanding at most
// Settings must stay stable while busy and len is limited to 2**ADDR_W-1 words
`timescale 1ns/100ps
`default_nettype none

module copy_engine #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 10
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                start,
   input  mem_pkg::op_t        op,
   input  logic [ADDR_W-1:0]   src_addr,
   input  logic [ADDR_W-1:0]   dst_addr,
   input  logic [ADDR_W-1:0]   len,
   input  logic [DATA_W-1:0]   pattern,
   input  logic [DATA_W/8-1:0] mask,
   input  logic [DATA_W-1:0]   avmm_readdata,
   input  logic                avmm_readdatavalid,
   input  logic                avmm_waitrequest,
   output logic                busy,
   output logic                done,
   output logic [DATA_W-1:0]   signature,
   output logic [ADDR_W-1:0]   avmm_address,
   output logic                avmm_read,
   output logic                avmm_write,
   output logic [DATA_W-1:0]   avmm_writedata,
   output logic [DATA_W/8-1:0] avmm_byteenable
);

   import mem_pkg::*;

   localparam int BE_W = DATA_W / 8;

   // State indices used to build the one-hot codes
   typedef enum {
      idle_i,
      read_req_i,
      read_wait_i,
      write_i,
      finish_i
   } state_idx_t;

   typedef enum logic [4:0] {
      IDLE      = 5'b1 << idle_i,
      READ_REQ  = 5'b1 << read_req_i,
      READ_WAIT = 5'b1 << read_wait_i,
      WRITE     = 5'b1 << write_i,
      FINISH    = 5'b1 << finish_i
   } state_t;

   state_t            state;
   state_t            next_state;
   logic [ADDR_W-1:0] cnt;
   logic [ADDR_W-1:0] src_ptr;
   logic [ADDR_W-1:0] dst_ptr;
   logic [DATA_W-1:0] rdata_q;
   logic              last;

   // The word in flight is the final one when a single word remains
   assign last = (cnt == ADDR_W'(1));

   // Bus outputs decode straight from the state register
   assign avmm_read       = (state == READ_REQ);
   assign avmm_write      = (state == WRITE);
   assign avmm_address    = (state == WRITE) ? dst_ptr : src_ptr;
   assign avmm_writedata  = (op == OP_FILL) ? pattern : rdata_q;
   assign avmm_byteenable = (op == OP_FILL) ? mask : {BE_W{1'b1}};

   // Busy covers every state that owns the bus and done marks FINISH
   assign busy = !(state == IDLE || state == FINISH);
   assign done = (state == FINISH);

   always_comb begin
      next_state = state;
      unique case (state)
         IDLE: begin
            if (start) begin
               if (len == '0) begin
                  next_state = FINISH;
               end else if (op == OP_FILL) begin
                  next_state = WRITE;
               end else begin
                  next_state = READ_REQ;
               end
            end
         end
         READ_REQ: begin
            if (!avmm_waitrequest) begin
               next_state = READ_WAIT;
            end
         end
         READ_WAIT: begin
            if (avmm_readdatavalid) begin
               if (op == OP_COPY) begin
                  next_state = WRITE;
               end else if (last) begin
                  next_state = FINISH;
               end else begin
                  next_state = READ_REQ;
               end
            end
         end
         WRITE: begin
            if (!avmm_waitrequest) begin
               if (last) begin
                  next_state = FINISH;
               end else if (op == OP_FILL) begin
                  next_state = WRITE;
               end else begin
                  next_state = READ_REQ;
               end
            end
         end
         FINISH:  next_state = IDLE;
         default: next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= IDLE;
         cnt       <= '0;
         src_ptr   <= '0;
         dst_ptr   <= '0;
         signature <= '0;
      end else begin
         state <= next_state;
         // Pointers and the count load on start and the signature restarts
         if (state == IDLE && start) begin
            cnt       <= len;
            src_ptr   <= src_addr;
            dst_ptr   <= dst_addr;
            signature <= '0;
         end
         if (state == READ_WAIT && avmm_readdatavalid) begin
            src_ptr <= src_ptr + 1'b1;
            // CHECK retires its word here since it never writes
            if (op != OP_COPY) begin
               signature <= signature ^ avmm_readdata;
               cnt       <= cnt - 1'b1;
            end
         end
         if (state == WRITE && !avmm_waitrequest) begin
            dst_ptr <= dst_ptr + 1'b1;
            cnt     <= cnt - 1'b1;
         end
      end
   end

   // Holding register for the COPY word between readdatavalid and the write
   always_ff @(posedge clk) begin
      if (state == READ_WAIT && avmm_readdatavalid) begin
         rdata_q <= avmm_readdata;
      end
   end

endmodule

`default_nettype wire

/* flist.f */
mem_pkg.sv
copy_csr.sv
copy_engine.sv
avmm_mem_model.sv
mem_test_top.sv
mem_test_assertions.sv
tb_mem_test.sv

/* mem_pkg.sv */
// Shared operation and register codes for the memory test engine
// The control word needs DATA_W of at least 3 to hold the op code and start bit
`default_nettype none

package mem_pkg;

   // Width of the host configuration address
   localparam int CFG_ADDR_W = 3;

   // Bit positions inside a control register write
   localparam int CTRL_OP_LSB    = 0;
   localparam int CTRL_START_BIT = 2;

   // Operation codes carried in the low bits of the control word
   typedef enum logic [1:0] {
      OP_COPY  = 2'd0,
      OP_FILL  = 2'd1,
      OP_CHECK = 2'd2
   } op_t;

   // Register address codes seen on cfg_addr
   typedef enum logic [CFG_ADDR_W-1:0] {
      REG_SRC     = 3'd0,
      REG_DST     = 3'd1,
      REG_LEN     = 3'd2,
      REG_PATTERN = 3'd3,
      REG_MASK    = 3'd4,
      REG_CTRL    = 3'd5
   } reg_t;

endpackage

`default_nettype wire

/* mem_test_assertions.sv */
// Bus and status properties bound into every copy_engine instance
// Assumes a single outstanding read and waitrequest held low
`timescale 1ns/100ps
`default_nettype none

module mem_test_assertions (
   input logic clk,
   input logic rst_n,
   input logic busy,
   input logic done,
   input logic avmm_read,
   input logic avmm_write,
   input logic avmm_readdatavalid
);

   // The engine drives one address for both directions, so never both at once
   a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
      !(avmm_read && avmm_write))
      else $error("read and write are high in the same cycle");

   // Done lasts exactly one cycle
   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      done |=> !done)
      else $error("done stayed high for more than one cycle");

   // The only busy state with neither strobe is the read wait
   a_valid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
      avmm_readdatavalid |-> (busy && !avmm_read && !avmm_write))
      else $error("readdatavalid arrived while the engine was not waiting");

endmodule

bind copy_engine mem_test_assertions u_assert (
   .clk                (clk),
   .rst_n              (rst_n),
   .busy               (busy),
   .done               (done),
   .avmm_read          (avmm_read),
   .avmm_write         (avmm_write),
   .avmm_readdatavalid (avmm_readdatavalid)
);

`default_nettype wire

/* mem_test_top.sv */
// Memory test subsystem with register block, engine and memory model
// Status is visible on ports only since registers cannot be read back
`timescale 1ns/100ps
`default_nettype none

module mem_test_top #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 10
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cfg_write,
   input  mem_pkg::reg_t     cfg_addr,
   input  logic [DATA_W-1:0] cfg_wdata,
   output logic              busy,
   output logic              done,
   output logic [DATA_W-1:0] signature
);

   // Settings from the register block to the engine
   logic                start;
   mem_pkg::op_t        op;
   logic [ADDR_W-1:0]   src_addr;
   logic [ADDR_W-1:0]   dst_addr;
   logic [ADDR_W-1:0]   len;
   logic [DATA_W-1:0]   pattern;
   logic [DATA_W/8-1:0] mask;

   // Avalon-MM bus between the engine and the memory
   logic [ADDR_W-1:0]   avmm_address;
   logic                avmm_read;
   logic                avmm_write;
   logic [DATA_W-1:0]   avmm_writedata;
   logic [DATA_W/8-1:0] avmm_byteenable;
   logic [DATA_W-1:0]   avmm_readdata;
   logic                avmm_readdatavalid;
   logic                avmm_waitrequest;

   copy_csr #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_csr (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .busy      (busy),
      .start     (start),
      .op        (op),
      .src_addr  (src_addr),
      .dst_addr  (dst_addr),
      .len       (len),
      .pattern   (pattern),
      .mask      (mask)
   );

   copy_engine #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_engine (
      .clk                (clk),
      .rst_n              (rst_n),
      .start              (start),
      .op                 (op),
      .src_addr           (src_addr),
      .dst_addr           (dst_addr),
      .len                (len),
      .pattern            (pattern),
      .mask               (mask),
      .avmm_readdata      (avmm_readdata),
      .avmm_readdatavalid (avmm_readdatavalid),
      .avmm_waitrequest   (avmm_waitrequest),
      .busy               (busy),
      .done               (done),
      .signature          (signature),
      .avmm_address       (avmm_address),
      .avmm_read          (avmm_read),
      .avmm_write         (avmm_write),
      .avmm_writedata     (avmm_writedata),
      .avmm_byteenable    (avmm_byteenable)
   );

   avmm_mem_model #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_mem (
      .clk                (clk),
      .rst_n              (rst_n),
      .avmm_address       (avmm_address),
      .avmm_read          (avmm_read),
      .avmm_write         (avmm_write),
      .avmm_writedata     (avmm_writedata),
      .avmm_byteenable    (avmm_byteenable),
      .avmm_waitrequest   (avmm_waitrequest),
      .avmm_readdata      (avmm_readdata),
      .avmm_readdatavalid (avmm_readdatavalid)
   );

endmodule

`default_nettype wire

/* tb_mem_test.sv */
// Testbench for the memory test subsystem at DATA_W 32 and ADDR_W 10
// Table ranges must not wrap the address space and len stays below 2**ADDR_W
`timescale 1ns/100ps
`default_nettype none

module tb_mem_test;

   import mem_pkg::*;

   localparam int DATA_W  = 32;
   localparam int ADDR_W  = 10;
   localparam int BE_W    = DATA_W / 8;
   localparam int DEPTH   = 2 ** ADDR_W;
   localparam int N_TESTS = 8;

   // One row of the stimulus table with its check range and expected outcome
   typedef struct packed {
      op_t               op;
      logic [ADDR_W-1:0] src;
      logic [ADDR_W-1:0] dst;
      logic [ADDR_W-1:0] len;
      logic [DATA_W-1:0] pattern;
      logic [BE_W-1:0]   mask;
      logic [ADDR_W-1:0] chk_src;
      logic [ADDR_W-1:0] chk_len;
      logic              exp_zero;
      logic              busy_wr;
   } entry_t;

   logic              clk;
   logic              rst_n;
   logic              cfg_write;
   reg_t              cfg_addr;
   logic [DATA_W-1:0] cfg_wdata;
   logic              busy;
   logic              done;
   logic [DATA_W-1:0] signature;

   entry_t            tbl [N_TESTS];
   logic [DATA_W-1:0] ref_mem [DEPTH];
   logic [31:0]       lcg_state;
   int                cycles = 0;
   int                limit;
   int                errors;
   int                failed;

   mem_test_top #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W)
   ) u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .busy      (busy),
      .done      (done),
      .signature (signature)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // Watchdog over the whole run, the limit is set before the first edge
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= limit) begin
         $display("Timeout: the run did not finish within %0d cycles", limit);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // XOR of a range of the reference array, the expected CHECK signature
   function automatic logic [DATA_W-1:0] ref_xor(input logic [ADDR_W-1:0] a,
                                                 input logic [ADDR_W-1:0] n);
      logic [DATA_W-1:0] acc;
      acc = '0;
      for (int i = 0; i < n; i++) begin
         acc = acc ^ ref_mem[ADDR_W'(a + i)];
      end
      return acc;
   endfunction

   function automatic string op_name(input op_t op);
      case (op)
         OP_COPY: return "COPY";
         OP_FILL: return "FILL";
         default: return "CHECK";
      endcase
   endfunction

   task automatic set_entry(input int idx, input op_t op, input int src, input int dst,
                            input int len, input logic [DATA_W-1:0] pattern,
                            input logic [BE_W-1:0] mask, input int chk_src,
                            input int chk_len, input logic exp_zero, input logic busy_wr);
      entry_t e;
      e.op       = op;
      e.src      = ADDR_W'(src);
      e.dst      = ADDR_W'(dst);
      e.len      = ADDR_W'(len);
      e.pattern  = pattern;
      e.mask     = mask;
      e.chk_src  = ADDR_W'(chk_src);
      e.chk_len  = ADDR_W'(chk_len);
      e.exp_zero = exp_zero;
      e.busy_wr  = busy_wr;
      tbl[idx]   = e;
   endtask

   // FILL patterns are drawn from the LCG in table order
   task automatic load_table;
      // Reset contents, whole array split since len cannot reach DEPTH
      set_entry(0, OP_CHECK, 0, 0, 1023, '0, '0, 1023, 1, 1'b1, 1'b0);
      lcg_state = lcg_next(lcg_state);
      set_entry(1, OP_FILL, 0, 16, 8, lcg_state, 4'hf, 16, 8, 1'b1, 1'b0);
      lcg_state = lcg_next(lcg_state);
      set_entry(2, OP_FILL, 0, 100, 5, lcg_state, 4'hf, 100, 5, 1'b0, 1'b0);
      // Partial mask over the words written by row 1
      lcg_state = lcg_next(lcg_state);
      set_entry(3, OP_FILL, 0, 18, 4, lcg_state, 4'b0101, 16, 8, 1'b0, 1'b0);
      set_entry(4, OP_COPY, 16, 200, 8, '0, '0, 200, 8, 1'b0, 1'b0);
      set_entry(5, OP_COPY, 100, 300, 5, '0, '0, 300, 5, 1'b0, 1'b0);
      // Zero length must leave the target words at zero
      lcg_state = lcg_next(lcg_state);
      set_entry(6, OP_FILL, 0, 500, 0, lcg_state, 4'hf, 500, 4, 1'b1, 1'b0);
      // Odd length so a stray pattern, mask or op change shows in the signature
      lcg_state = lcg_next(lcg_state);
      set_entry(7, OP_FILL, 0, 600, 7, lcg_state, 4'hf, 600, 8, 1'b0, 1'b1);
   endtask

   // Reference model of FILL and COPY, copies go word by word upwards
   task automatic apply_ref(input entry_t e);
      for (int i = 0; i < e.len; i++) begin
         if (e.op == OP_FILL) begin
            for (int b = 0; b < BE_W; b++) begin
               if (e.mask[b]) begin
                  ref_mem[ADDR_W'(e.dst + i)][8*b +: 8] = e.pattern[8*b +: 8];
               end
            end
         end else if (e.op == OP_COPY) begin
            ref_mem[ADDR_W'(e.dst + i)] = ref_mem[ADDR_W'(e.src + i)];
         end
      end
   endtask

   // Called on a rising edge and returns on the edge that sampled the write
   task automatic write_reg(input reg_t a, input logic [DATA_W-1:0] d);
      cfg_write <= 1'b1;
      cfg_addr  <= a;
      cfg_wdata <= d;
      @(posedge clk);
      cfg_write <= 1'b0;
   endtask

   // Done and signature are sampled on the falling edge
   task automatic wait_done(output logic [DATA_W-1:0] sig);
      do begin
         @(negedge clk);
      end while (!done);
      sig = signature;
      @(posedge clk);
   endtask

   task automatic run_op(input op_t op, input logic [ADDR_W-1:0] src,
                         input logic [ADDR_W-1:0] dst, input logic [ADDR_W-1:0] len,
                         input logic [DATA_W-1:0] pattern, input logic [BE_W-1:0] mask,
                         input logic busy_wr, output logic [DATA_W-1:0] sig);
      write_reg(REG_SRC, DATA_W'(src));
      write_reg(REG_DST, DATA_W'(dst));
      write_reg(REG_LEN, DATA_W'(len));
      write_reg(REG_PATTERN, pattern);
      write_reg(REG_MASK, DATA_W'(mask));
      write_reg(REG_CTRL, DATA_W'(1 << CTRL_START_BIT) | DATA_W'(op));
      if (busy_wr) begin
         // First lands with start pending, the rest while the engine is busy
         write_reg(REG_PATTERN, ~pattern);
         write_reg(REG_MASK, DATA_W'(~mask));
         write_reg(REG_CTRL, DATA_W'(OP_CHECK));
      end
      wait_done(sig);
   endtask

   task automatic check_sig(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp, inout bit ok);
      if (got !== exp) begin
         $display("Error at %0t: signature (%s) = %h, expected %h", $time, what, got, exp);
         errors++;
         ok = 1'b0;
      end
   endtask

   initial begin
      entry_t            e;
      logic [DATA_W-1:0] sig;
      logic [DATA_W-1:0] src_sig;
      bit                ok;
      int                words;
      rst_n     = 1'b0;
      cfg_write = 1'b0;
      cfg_addr  = REG_SRC;
      cfg_wdata = '0;
      errors    = 0;
      failed    = 0;
      lcg_state = 32'h0503_ed6a;
      for (int i = 0; i < DEPTH; i++) begin
         ref_mem[i] = '0;
      end
      load_table();
      // Every word of every operation and check counts four cycles
      words = 0;
      for (int t = 0; t < N_TESTS; t++) begin
         words += tbl[t].len + tbl[t].chk_len;
         if (tbl[t].op == OP_COPY) begin
            words += tbl[t].len;
         end
      end
      limit = 4 * words + 200;

      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      if (busy !== 1'b0) begin
         $display("Error at %0t: busy = %b, expected 0", $time, busy);
         errors++;
      end
      if (done !== 1'b0) begin
         $display("Error at %0t: done = %b, expected 0", $time, done);
         errors++;
      end

      for (int t = 0; t < N_TESTS; t++) begin
         e  = tbl[t];
         ok = 1'b1;
         run_op(e.op, e.src, e.dst, e.len, e.pattern, e.mask, e.busy_wr, sig);
         apply_ref(e);
         if (e.op == OP_CHECK) begin
            check_sig("operation", sig, ref_xor(e.src, e.len), ok);
            if (e.exp_zero) begin
               check_sig("operation", sig, '0, ok);
            end
         end
         // Readback CHECK over the chosen range
         run_op(OP_CHECK, e.chk_src, '0, e.chk_len, '0, '0, 1'b0, sig);
         check_sig("check", sig, ref_xor(e.chk_src, e.chk_len), ok);
         if (e.exp_zero) begin
            check_sig("check", sig, '0, ok);
         end
         if (e.op == OP_COPY) begin
            // Source and destination of a copy must fold to the same value
            run_op(OP_CHECK, e.src, '0, e.len, '0, '0, 1'b0, src_sig);
            check_sig("destination vs source", sig, src_sig, ok);
         end
         if (!ok) begin
            failed++;
         end
         $display("Test %0d %s len %0d: %s", t, op_name(e.op), e.len,
                  ok ? "passed" : "failed");
      end

      $display("Tests run: %0d, tests failed: %0d, errors: %0d", N_TESTS, failed, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire
